// ==== hw/qbus_pkg.sv ====
package qbus_pkg;

   localparam int AW           = 16;  // address and data width
   localparam int RPLY_TIMEOUT = 63;  // reply wait cycles before bus error
   localparam int TMR_W        = 6;   // reply timer width
   localparam int IRQ_W        = 4;   // interrupt request vector width

   // host operations
   typedef enum logic [2:0]
   {
      OP_READ       = 3'd0,           // word read
      OP_WRITE      = 3'd1,           // word write
      OP_WRITE_BYTE = 3'd2,           // byte write, lane from addr[0]
      OP_IACK       = 3'd3,           // interrupt vector read
      OP_FAST_READ  = 3'd4            // unaddressed status word, no bus cycle
   } bus_op_e;

   // service operations, one action per cycle
   typedef enum logic [2:0]
   {
      SVC_NONE      = 3'd0,
      SVC_CLR_INIT  = 3'd1,           // deassert peripheral init
      SVC_CLR_BERR  = 3'd2,           // clear bus error and refresh flag
      SVC_SET_RFSH  = 3'd3,           // set refresh flag
      SVC_SET_INIT  = 3'd4,           // assert peripheral init
      SVC_CLR_ACLO  = 3'd5,           // clear power fail latch
      SVC_CLR_EVNT  = 3'd6            // clear timer event latch
   } svc_op_e;

   // bus cycle fsm states
   typedef enum logic [2:0]
   {
      ST_IDLE       = 3'd0,
      ST_ADDR       = 3'd1,           // address phase, sync rises
      ST_DATA       = 3'd2,           // din/dout until rply or timeout
      ST_DONE       = 3'd3,           // strobe dropped, wait rply low
      ST_RELEASE    = 3'd4,           // sync low, response pulse
      ST_FAST       = 3'd5            // fast read response, bus untouched
   } cyc_state_e;

endpackage

// ==== hw/qbus_reply_timer.sv ====
`timescale 1ns/1ps

module qbus_reply_timer
(
   input  logic c2,
   input  logic dclo,
   input  logic tmr_run,          // high while waiting for rply
   output logic tmr_expired       // reply timeout reached
);

   logic [qbus_pkg::TMR_W-1:0] cnt;
   logic                       at_limit;

   assign at_limit = (cnt == qbus_pkg::TMR_W'(qbus_pkg::RPLY_TIMEOUT));

   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
         cnt <= '0;
      else if (!tmr_run)
         cnt <= '0;                  // cleared between data phases
      else if (!at_limit)
         cnt <= cnt + 1'b1;          // saturate at the limit
   end

   assign tmr_expired = at_limit;

   // count holds at the limit and never wraps past it
   a_cnt_max: assert property (@(posedge c2) disable iff (dclo)
      (tmr_run && at_limit) |=> at_limit);

endmodule

// ==== hw/qbus_cycle_fsm.sv ====
`timescale 1ns/1ps

module qbus_cycle_fsm
(
   input  logic                       c2,
   input  logic                       dclo,
   input  logic                       req_valid,
   input  qbus_pkg::bus_op_e          req_op,
   input  logic [qbus_pkg::AW-1:0]    req_addr,
   input  logic [qbus_pkg::AW-1:0]    req_wdata,
   output logic                       req_ready,
   output logic                       rsp_valid,
   output logic                       rsp_err,
   input  logic                       bus_rply,
   input  logic                       bus_init,
   input  logic                       bus_free,   // no dma owner
   input  logic                       tmr_expired,
   output logic                       tmr_run,
   output logic                       bus_sync,
   output logic                       bus_din,
   output logic                       bus_dout,
   output logic                       bus_wtbt,
   output logic                       bus_iako,
   output logic                       cap_en,     // data path capture strobe
   output logic [1:0]                 ad_sel,     // 00 off, 01 addr, 10 wdata, 11 fast word
   output logic                       fsm_idle,
   output logic                       berr_set
);

   qbus_pkg::cyc_state_e state, state_nx;
   qbus_pkg::bus_op_e    op_q;                   // operation of the running cycle
   logic                 byte_q;                 // byte write flag
   logic                 err_q;                  // cycle ended on timeout
   logic                 accept;
   logic                 is_wr;
   logic                 is_rd;
   logic                 fast_req;
   logic                 timeout;

   assign accept   = req_valid & req_ready;
   assign fast_req = (req_op == qbus_pkg::OP_FAST_READ);
   assign is_wr    = (op_q == qbus_pkg::OP_WRITE) | byte_q;
   assign is_rd    = ~is_wr;                     // read and iack both use din
   assign timeout  = (state == qbus_pkg::ST_DATA) & ~bus_rply & tmr_expired;

   always_comb
   begin
      state_nx = state;
      case (state)
         qbus_pkg::ST_IDLE:
            if (accept)
               state_nx = fast_req ? qbus_pkg::ST_FAST : qbus_pkg::ST_ADDR;
         qbus_pkg::ST_ADDR:
            state_nx = qbus_pkg::ST_DATA;        // address phase is one cycle
         qbus_pkg::ST_DATA:
            if (bus_rply)
               state_nx = qbus_pkg::ST_DONE;
            else if (tmr_expired)
               state_nx = qbus_pkg::ST_RELEASE;  // no reply, abort
         qbus_pkg::ST_DONE:
            if (!bus_rply)
               state_nx = qbus_pkg::ST_RELEASE;
         default:
            state_nx = qbus_pkg::ST_IDLE;        // release and fast end here
      endcase
   end

   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
      begin
         state  <= qbus_pkg::ST_IDLE;
         op_q   <= qbus_pkg::OP_READ;
         byte_q <= 1'b0;
         err_q  <= 1'b0;
      end
      else
      begin
         state <= state_nx;
         if (accept)
         begin
            op_q   <= req_op;
            byte_q <= (req_op == qbus_pkg::OP_WRITE_BYTE);
            err_q  <= 1'b0;                      // fresh status per request
         end
         else if (timeout)
            err_q <= 1'b1;
      end
   end

   assign fsm_idle  = (state == qbus_pkg::ST_IDLE);
   assign req_ready = fsm_idle & bus_free & ~bus_init;
   assign rsp_valid = (state == qbus_pkg::ST_RELEASE) | (state == qbus_pkg::ST_FAST);
   assign rsp_err   = rsp_valid & err_q;
   assign berr_set  = timeout;
   assign tmr_run   = (state == qbus_pkg::ST_DATA);  // timer counts data phase only

   assign bus_sync  = (state == qbus_pkg::ST_ADDR) | (state == qbus_pkg::ST_DATA) |
                      (state == qbus_pkg::ST_DONE);
   assign bus_din   = (state == qbus_pkg::ST_DATA) & is_rd;
   assign bus_dout  = (state == qbus_pkg::ST_DATA) & is_wr;
   assign bus_iako  = (state == qbus_pkg::ST_DATA) & (op_q == qbus_pkg::OP_IACK);
   assign bus_wtbt  = ((state == qbus_pkg::ST_ADDR) & is_wr) |   // write status
                      ((state == qbus_pkg::ST_DATA) & byte_q);   // byte status

   // slave data is valid while rply is high
   assign cap_en = (fsm_idle & accept & fast_req) |
                   ((state == qbus_pkg::ST_DATA) & is_rd & bus_rply);

   always_comb
   begin
      ad_sel = 2'b00;
      case (state)
         qbus_pkg::ST_IDLE: if (accept && fast_req) ad_sel = 2'b11;
         qbus_pkg::ST_ADDR: ad_sel = 2'b01;
         qbus_pkg::ST_DATA: if (is_wr) ad_sel = 2'b10;
         default:           ad_sel = 2'b00;
      endcase
   end

   a_strobe_excl: assert property (@(posedge c2) disable iff (dclo)
      !(bus_din && bus_dout));
   a_strobe_sync: assert property (@(posedge c2) disable iff (dclo)
      (bus_din || bus_dout) |-> bus_sync);
   // host keeps a stalled request unchanged
   a_req_hold: assert property (@(posedge c2) disable iff (dclo)
      (req_valid && !req_ready) |=> req_valid && $stable(req_op) &&
      $stable(req_addr) && $stable(req_wdata));

endmodule

// ==== hw/qbus_event_latch.sv ====
`timescale 1ns/1ps

module qbus_event_latch
(
   input  logic                       c2,
   input  logic                       dclo,
   input  qbus_pkg::svc_op_e          svc_op,
   input  logic                       berr_set,   // timeout from the fsm
   input  logic                       evnt,
   input  logic                       virq,
   input  logic                       halt,
   input  logic                       aclo,
   input  logic                       rfrq,
   output logic [qbus_pkg::IRQ_W-1:0] irq_req,
   output logic                       bus_init,
   output logic                       bus_dref,
   output logic                       berr_flag,
   output logic                       aclo_pend
);

   logic evnt_d, aclo_d, rfrq_d;          // edge detector history
   logic evnt_rq;                         // timer event latch
   logic aclo_rq;                         // power fail latch
   logic dref_rq;                         // refresh request latch
   logic init_st;
   logic dref_st;
   logic berr_st;

   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
      begin
         evnt_d <= 1'b0;
         aclo_d <= 1'b0;
         rfrq_d <= 1'b0;
      end
      else
      begin
         evnt_d <= evnt;
         aclo_d <= aclo;
         rfrq_d <= rfrq;
      end
   end

   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
      begin
         evnt_rq <= 1'b0;
         aclo_rq <= 1'b0;
         dref_rq <= 1'b0;
         init_st <= 1'b1;                 // peripherals held in reset
         dref_st <= 1'b0;
         berr_st <= 1'b0;
         irq_req <= '0;
      end
      else
      begin
         if (evnt && !evnt_d)
            evnt_rq <= 1'b1;
         else if (svc_op == qbus_pkg::SVC_CLR_EVNT)
            evnt_rq <= 1'b0;

         if (aclo && !aclo_d)
            aclo_rq <= 1'b1;
         else if (svc_op == qbus_pkg::SVC_CLR_ACLO)
            aclo_rq <= 1'b0;

         if (svc_op == qbus_pkg::SVC_SET_RFSH)
            dref_rq <= 1'b0;              // refresh taken
         else if (rfrq && !rfrq_d)
            dref_rq <= 1'b1;

         if (svc_op == qbus_pkg::SVC_SET_INIT)
            init_st <= 1'b1;
         else if (svc_op == qbus_pkg::SVC_CLR_INIT)
            init_st <= 1'b0;

         if (svc_op == qbus_pkg::SVC_SET_RFSH)
            dref_st <= 1'b1;
         else if (svc_op == qbus_pkg::SVC_CLR_BERR)
            dref_st <= 1'b0;

         if (init_st || svc_op == qbus_pkg::SVC_CLR_BERR)
            berr_st <= 1'b0;              // init wins over a late timeout
         else if (berr_set)
            berr_st <= 1'b1;

         irq_req <= {dref_rq, aclo_rq | halt, evnt_rq, virq};
      end
   end

   assign bus_init  = init_st;
   assign bus_dref  = dref_st;
   assign berr_flag = berr_st;
   assign aclo_pend = aclo_rq;

endmodule

// ==== hw/qbus_dma_arbiter.sv ====
`timescale 1ns/1ps

module qbus_dma_arbiter
(
   input  logic c2,
   input  logic dclo,
   input  logic bus_dmr,          // dma request from the master
   input  logic bus_sack,         // master has taken the bus
   input  logic fsm_idle,         // no cycle running, sync low
   input  logic bus_init,
   output logic bus_dmgo,         // grant
   output logic bus_free          // host may start cycles
);

   logic dmr_q;                   // registered request
   logic dma_own;                 // bus held by the master
   logic dmgo_q;

   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
      begin
         dmr_q   <= 1'b0;
         dma_own <= 1'b0;
         dmgo_q  <= 1'b0;
      end
      else
      begin
         dmr_q   <= bus_dmr;
         dma_own <= dmr_q | bus_sack;   // drops a cycle after sack falls
         if (dmgo_q)
            dmgo_q <= ~bus_sack;        // grant ends once sack seen
         else
            dmgo_q <= dmr_q & fsm_idle & ~bus_init & ~bus_sack;
      end
   end

   assign bus_dmgo = dmgo_q;
   assign bus_free = ~(dmr_q | dma_own);

   // no grant while the fsm owns the bus
   a_dmgo_sync: assert property (@(posedge c2) disable iff (dclo)
      bus_dmgo |-> fsm_idle);

endmodule

// ==== hw/qbus_data_path.sv ====
`timescale 1ns/1ps

module qbus_data_path
(
   input  logic                    c2,
   input  logic                    dclo,
   input  logic                    req_valid,
   input  logic                    req_ready,
   input  logic [qbus_pkg::AW-1:0] req_addr,
   input  logic [qbus_pkg::AW-1:0] req_wdata,
   input  logic [1:0]              ad_sel,     // 00 off, 01 addr, 10 wdata, 11 fast word
   input  logic                    cap_en,
   input  logic [qbus_pkg::AW-1:0] bus_ad_in,
   input  logic                    berr_flag,
   input  logic                    aclo_pend,
   input  logic                    aclo,
   input  logic [1:0]              bsel,       // boot mode selector
   output logic [qbus_pkg::AW-1:0] bus_ad_out,
   output logic                    bus_ad_oe,
   output logic [qbus_pkg::AW-1:0] rsp_rdata
);

   logic [qbus_pkg::AW-1:0] addr_q;
   logic [qbus_pkg::AW-1:0] wdata_q;
   logic [qbus_pkg::AW-1:0] rd_q;
   logic [qbus_pkg::AW-1:0] fast_word;
   logic                    accept;

   assign accept    = req_valid & req_ready;
   assign fast_word = {{(qbus_pkg::AW-4){1'b0}}, aclo | aclo_pend, berr_flag, bsel};

   always_ff @(posedge c2)
   begin
      if (accept)
      begin
         addr_q  <= req_addr;
         wdata_q <= req_wdata;
      end
   end

   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
         rd_q <= '0;
      else if (cap_en)
         rd_q <= (ad_sel == 2'b11) ? fast_word : bus_ad_in;
      else if (accept)
         rd_q <= '0;              // writes and timeouts answer zero
   end

   assign bus_ad_out = (ad_sel == 2'b01) ? addr_q  :
                       (ad_sel == 2'b10) ? wdata_q : '0;
   assign bus_ad_oe  = ad_sel[0] ^ ad_sel[1];   // drive for addr or wdata only
   assign rsp_rdata  = rd_q;

endmodule

// ==== hw/qbus_cpu_if.sv ====
`timescale 1ns/1ps

module qbus_cpu_if
(
   input  logic                       c2,
   input  logic                       dclo,
   input  logic                       req_valid,
   input  qbus_pkg::bus_op_e          req_op,
   input  logic [qbus_pkg::AW-1:0]    req_addr,
   input  logic [qbus_pkg::AW-1:0]    req_wdata,
   output logic                       req_ready,
   output logic                       rsp_valid,
   output logic [qbus_pkg::AW-1:0]    rsp_rdata,
   output logic                       rsp_err,
   input  qbus_pkg::svc_op_e          svc_op,
   output logic                       bus_sync,
   output logic                       bus_din,
   output logic                       bus_dout,
   output logic                       bus_wtbt,
   output logic                       bus_iako,
   output logic [qbus_pkg::AW-1:0]    bus_ad_out,
   output logic                       bus_ad_oe,
   output logic                       bus_init,
   output logic                       bus_dmgo,
   output logic                       bus_dref,
   input  logic [qbus_pkg::AW-1:0]    bus_ad_in,
   input  logic                       bus_rply,
   input  logic                       bus_dmr,
   input  logic                       bus_sack,
   input  logic                       evnt,
   input  logic                       virq,
   input  logic                       halt,
   input  logic                       aclo,
   input  logic                       rfrq,
   input  logic [1:0]                 bsel,
   output logic [qbus_pkg::IRQ_W-1:0] irq_req
);

   logic       tmr_run, tmr_expired;
   logic       cap_en;
   logic [1:0] ad_sel;
   logic       fsm_idle, bus_free;
   logic       berr_set, berr_flag, aclo_pend;

   qbus_cycle_fsm i_fsm
   (
      .c2(c2), .dclo(dclo),
      .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
      .req_wdata(req_wdata), .req_ready(req_ready),
      .rsp_valid(rsp_valid), .rsp_err(rsp_err),
      .bus_rply(bus_rply), .bus_init(bus_init), .bus_free(bus_free),
      .tmr_expired(tmr_expired), .tmr_run(tmr_run),
      .bus_sync(bus_sync), .bus_din(bus_din), .bus_dout(bus_dout),
      .bus_wtbt(bus_wtbt), .bus_iako(bus_iako),
      .cap_en(cap_en), .ad_sel(ad_sel), .fsm_idle(fsm_idle), .berr_set(berr_set)
   );

   qbus_reply_timer i_timer
   (
      .c2(c2), .dclo(dclo), .tmr_run(tmr_run), .tmr_expired(tmr_expired)
   );

   qbus_event_latch i_events
   (
      .c2(c2), .dclo(dclo), .svc_op(svc_op), .berr_set(berr_set),
      .evnt(evnt), .virq(virq), .halt(halt), .aclo(aclo), .rfrq(rfrq),
      .irq_req(irq_req), .bus_init(bus_init), .bus_dref(bus_dref),
      .berr_flag(berr_flag), .aclo_pend(aclo_pend)
   );

   qbus_dma_arbiter i_arbiter
   (
      .c2(c2), .dclo(dclo), .bus_dmr(bus_dmr), .bus_sack(bus_sack),
      .fsm_idle(fsm_idle), .bus_init(bus_init),
      .bus_dmgo(bus_dmgo), .bus_free(bus_free)
   );

   qbus_data_path i_data
   (
      .c2(c2), .dclo(dclo),
      .req_valid(req_valid), .req_ready(req_ready),
      .req_addr(req_addr), .req_wdata(req_wdata),
      .ad_sel(ad_sel), .cap_en(cap_en), .bus_ad_in(bus_ad_in),
      .berr_flag(berr_flag), .aclo_pend(aclo_pend), .aclo(aclo), .bsel(bsel),
      .bus_ad_out(bus_ad_out), .bus_ad_oe(bus_ad_oe), .rsp_rdata(rsp_rdata)
   );

endmodule

// ==== include/qbus_tb_vectors.svh ====
`ifndef QBUS_TB_VECTORS_SVH
`define QBUS_TB_VECTORS_SVH

// columns are action, host op, service code, addr (or level), wdata, expected and expected err
// expected is rdata for requests, irq_req for A_IRQ and {dref, init} for A_SVC
typedef enum logic [3:0]
{
   A_REQ, A_DMA, A_SVC, A_IRQ,           // host request, dma then request, service, irq check
   A_EVNT, A_ACLO, A_VIRQ, A_BSEL        // pin pulses and levels
} act_e;

typedef struct packed
{
   act_e              act;
   qbus_pkg::bus_op_e op;
   qbus_pkg::svc_op_e svc;
   logic [15:0]       addr;
   logic [15:0]       wdata;
   logic [15:0]       exp;
   logic              exp_err;
} vec_t;

vec_t vectors [32] = '{
   '{A_SVC, qbus_pkg::OP_READ, qbus_pkg::SVC_CLR_INIT, 16'h0000, 16'h0000, 16'h0000, 1'b0},
   '{A_SVC, qbus_pkg::OP_READ, qbus_pkg::SVC_SET_RFSH, 16'h0000, 16'h0000, 16'h0002, 1'b0},
   '{A_BSEL, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0002, 16'h0000, 16'h0000, 1'b0},
   '{A_REQ, qbus_pkg::OP_WRITE, qbus_pkg::SVC_NONE, 16'h0040, 16'h1234, 16'h0000, 1'b0},
   '{A_REQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0040, 16'h0000, 16'h1234, 1'b0},
   '{A_REQ, qbus_pkg::OP_WRITE, qbus_pkg::SVC_NONE, 16'h0042, 16'hbeef, 16'h0000, 1'b0},
   '{A_REQ, qbus_pkg::OP_WRITE_BYTE, qbus_pkg::SVC_NONE, 16'h0041, 16'hab00, 16'h0000, 1'b0},
   '{A_REQ, qbus_pkg::OP_WRITE_BYTE, qbus_pkg::SVC_NONE, 16'h0042, 16'h00c5, 16'h0000, 1'b0},
   '{A_REQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0040, 16'h0000, 16'hab34, 1'b0},
   '{A_REQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0042, 16'h0000, 16'hbec5, 1'b0},
   '{A_REQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0100, 16'h0000, 16'hda80, 1'b0},
   '{A_REQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0400, 16'h0000, 16'h0000, 1'b1},
   '{A_REQ, qbus_pkg::OP_FAST_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0006, 1'b0},
   '{A_SVC, qbus_pkg::OP_READ, qbus_pkg::SVC_CLR_BERR, 16'h0000, 16'h0000, 16'h0000, 1'b0},
   '{A_REQ, qbus_pkg::OP_FAST_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0002, 1'b0},
   '{A_EVNT, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0000, 1'b0},
   '{A_IRQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0002, 1'b0},
   '{A_ACLO, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0000, 1'b0},
   '{A_REQ, qbus_pkg::OP_FAST_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h000a, 1'b0},
   '{A_IRQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0006, 1'b0},
   '{A_VIRQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0001, 16'h0000, 16'h0000, 1'b0},
   '{A_IRQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0007, 1'b0},
   '{A_SVC, qbus_pkg::OP_READ, qbus_pkg::SVC_CLR_EVNT, 16'h0000, 16'h0000, 16'h0000, 1'b0},
   '{A_IRQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0005, 1'b0},
   '{A_SVC, qbus_pkg::OP_READ, qbus_pkg::SVC_CLR_ACLO, 16'h0000, 16'h0000, 16'h0000, 1'b0},
   '{A_IRQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0001, 1'b0},
   '{A_VIRQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0000, 1'b0},
   '{A_IRQ, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0000, 1'b0},
   '{A_BSEL, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0001, 16'h0000, 16'h0000, 1'b0},
   '{A_REQ, qbus_pkg::OP_FAST_READ, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0001, 1'b0},
   '{A_REQ, qbus_pkg::OP_IACK, qbus_pkg::SVC_NONE, 16'h0000, 16'h0000, 16'h0040, 1'b0},
   '{A_DMA, qbus_pkg::OP_READ, qbus_pkg::SVC_NONE, 16'h0042, 16'h0000, 16'hbec5, 1'b0}
};

`endif

// ==== sim/tb_qbus_cpu_if.sv ====
`timescale 1ns/1ps

module tb_qbus_cpu_if;

   logic                       c2 = 1'b0;
   logic                       dclo;
   logic                       req_valid;
   qbus_pkg::bus_op_e          req_op;
   logic [qbus_pkg::AW-1:0]    req_addr;
   logic [qbus_pkg::AW-1:0]    req_wdata;
   logic                       req_ready;
   logic                       rsp_valid;
   logic [qbus_pkg::AW-1:0]    rsp_rdata;
   logic                       rsp_err;
   qbus_pkg::svc_op_e          svc_op;
   logic                       bus_sync, bus_din, bus_dout, bus_wtbt, bus_iako;
   logic [qbus_pkg::AW-1:0]    bus_ad_out;
   logic                       bus_ad_oe, bus_init, bus_dmgo, bus_dref;
   logic [qbus_pkg::AW-1:0]    bus_ad_in;
   logic                       bus_rply, bus_dmr, bus_sack;
   logic                       evnt, virq, halt, aclo, rfrq;
   logic [1:0]                 bsel;
   logic [qbus_pkg::IRQ_W-1:0] irq_req;

   `include "qbus_tb_vectors.svh"

   logic [15:0] mem [256];                     // slave memory indexed by addr[8:1]
   logic [15:0] slv_addr;                      // address from the last address phase
   integer      seed = 32'h9a9d259b;
   int          slv_wait;                      // cycles left before rply
   int          dma_hold;                      // cycles left with sack high
   int          checks, errors, timeouts;
   int          hold_errors;                   // req_ready seen during dma
   int          iako_cycles;
   int          dma_req;                       // bumped per dma request
   int          dma_done;

   qbus_cpu_if i_qbus_cpu_if (.*);

   always #4 c2 = ~c2;                         // 8 ns period

   task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("FAIL %s expected %h actual %h", name, exp, act);
      end
   endtask

   // DUT output that a wait loop watches
   function automatic logic watched(input string sig);
      if (sig == "req_ready")
         return req_ready;
      else if (sig == "rsp_valid")
         return rsp_valid;
      else if (sig == "bus_dmgo")
         return bus_dmgo;
      return bus_sack;
   endfunction

   task automatic wait_high(input string sig, input string name, output int lat);
      lat = 0;
      while (!watched(sig) && lat < 200)
      begin
         @(posedge c2);
         #1;
         lat++;
      end
      if (!watched(sig))
      begin
         timeouts++;
         $display("timeout in %s: %s stayed low for %0d cycles", name, sig, lat);
      end
   endtask

   task automatic run_request(input string name, input vec_t v);
      int lat;
      int iako_before;
      iako_before = iako_cycles;
      req_op      = v.op;
      req_addr    = v.addr;
      req_wdata   = v.wdata;
      req_valid   = 1'b1;                      // held until ready
      wait_high("req_ready", name, lat);
      if (timeouts == 0)
      begin
         @(posedge c2);                        // transfer edge
         #1;
         req_valid = 1'b0;
         wait_high("rsp_valid", name, lat);
      end
      if (timeouts == 0)
      begin
         check_eq($sformatf("%s_rdata", name), v.exp, rsp_rdata);
         check_eq($sformatf("%s_err", name), 16'(v.exp_err), 16'(rsp_err));
         if (v.op == qbus_pkg::OP_FAST_READ)
            check_eq($sformatf("%s_latency", name), 16'd0, 16'(lat));
         if (v.op == qbus_pkg::OP_IACK)
            check_eq($sformatf("%s_iako", name), 16'd1, 16'(iako_cycles != iako_before));
      end
   endtask

   task automatic run_dma(input string name, input vec_t v);
      int lat;
      dma_req++;
      wait_high("bus_dmgo", name, lat);
      if (timeouts == 0)
         wait_high("bus_sack", name, lat);
      if (timeouts == 0)
      begin
         check_eq($sformatf("%s_held", name), 16'd0, 16'(req_ready));
         run_request(name, v);                 // queued behind the master
      end
   endtask

   task automatic apply_service(input string name, input vec_t v);
      svc_op = v.svc;
      @(posedge c2);
      #1;
      svc_op = qbus_pkg::SVC_NONE;             // held one cycle so it acts once
      check_eq(name, v.exp, 16'({bus_dref, bus_init}));
   endtask

   // slave memory and dma master react 1 ns after the edge
   initial
   begin
      bus_ad_in   = '0;
      bus_rply    = 1'b0;
      bus_dmr     = 1'b0;
      bus_sack    = 1'b0;
      slv_addr    = '0;
      slv_wait    = 0;
      dma_hold    = 0;
      dma_done    = 0;
      hold_errors = 0;
      iako_cycles = 0;
      for (int i = 0; i < 256; i++)
         mem[i] = {i[7:0], i[7:0]} ^ 16'h5a00;
      forever
      begin
         @(posedge c2);
         #1;
         if (bus_rply)
         begin
            if (!bus_din && !bus_dout)
            begin
               bus_rply  = 1'b0;               // release once the strobe is gone
               bus_ad_in = '0;
            end
         end
         else if (bus_sync && bus_ad_oe && !bus_din && !bus_dout)
         begin
            slv_addr = bus_ad_out;             // address phase
            slv_wait = 1 + int'($unsigned($random(seed)) % 4);
         end
         else if ((bus_din || bus_dout) && (bus_iako || slv_addr < 16'h0200))
         begin
            slv_wait--;
            if (slv_wait == 0)
            begin
               bus_rply = 1'b1;
               if (bus_iako)
                  bus_ad_in = 16'o0100;        // interrupt vector
               else if (bus_din)
                  bus_ad_in = mem[slv_addr[8:1]];
               else if (!bus_wtbt)
                  mem[slv_addr[8:1]] = bus_ad_out;
               else if (slv_addr[0])
                  mem[slv_addr[8:1]][15:8] = bus_ad_out[15:8];   // odd byte
               else
                  mem[slv_addr[8:1]][7:0] = bus_ad_out[7:0];
            end
         end

         if (bus_sack)
         begin
            if (dma_hold == 0)
               bus_sack = 1'b0;
            else
               dma_hold--;
         end
         else if (bus_dmr && bus_dmgo)
         begin
            bus_dmr  = 1'b0;
            bus_sack = 1'b1;                   // master owns the bus
            dma_hold = 1 + int'($unsigned($random(seed)) % 5);
            dma_done++;
         end
         else if (dma_req != dma_done)
            bus_dmr = 1'b1;

         if (!dclo && bus_iako)
            iako_cycles++;
         if (bus_sack && req_ready)
         begin
            hold_errors++;
            $display("req_ready was high while the DMA master held the bus");
         end
      end
   end

   initial
   begin
      vec_t  v;
      act_e  act;
      string name;
      dclo      = 1'b1;
      req_valid = 1'b0;
      req_op    = qbus_pkg::OP_READ;
      req_addr  = '0;
      req_wdata = '0;
      svc_op    = qbus_pkg::SVC_NONE;
      evnt      = 1'b0;
      virq      = 1'b0;
      halt      = 1'b0;
      aclo      = 1'b0;
      rfrq      = 1'b0;
      bsel      = 2'b00;
      checks    = 0;
      errors    = 0;
      timeouts  = 0;
      dma_req   = 0;

      repeat (16) @(posedge c2);
      #1;
      check_eq("reset_init", 16'd1, 16'(bus_init));
      check_eq("reset_irq", 16'd0, 16'(irq_req));
      check_eq("reset_strobes", 16'd0, 16'({bus_sync, bus_din, bus_dout, bus_wtbt, bus_iako,
               bus_ad_oe, bus_dmgo, bus_dref, req_ready, rsp_valid}));
      dclo = 1'b0;

      for (int i = 0; i < $size(vectors) && timeouts == 0; i++)
      begin
         v    = vectors[i];
         act  = v.act;
         name = $sformatf("v%0d_%s", i, act.name());
         case (act)
            A_REQ:  run_request(name, v);
            A_DMA:  run_dma(name, v);
            A_SVC:  apply_service(name, v);
            A_VIRQ: virq = v.addr[0];
            A_BSEL: bsel = v.addr[1:0];
            A_IRQ:
            begin
               repeat (2) @(posedge c2);       // latch plus irq register
               #1;
               check_eq(name, v.exp, 16'(irq_req));
            end
            A_EVNT, A_ACLO:
            begin
               evnt = (act == A_EVNT);
               aclo = (act == A_ACLO);
               @(posedge c2);
               #1;
               evnt = 1'b0;
               aclo = 1'b0;
            end
            default: ;
         endcase
      end

      $display("checks %0d, mismatches %0d, dma hold errors %0d, timeouts %0d",
               checks, errors, hold_errors, timeouts);
      if (errors == 0 && hold_errors == 0 && timeouts == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+include
hw/qbus_pkg.sv
hw/qbus_reply_timer.sv
hw/qbus_cycle_fsm.sv
hw/qbus_event_latch.sv
hw/qbus_dma_arbiter.sv
hw/qbus_data_path.sv
hw/qbus_cpu_if.sv
sim/tb_qbus_cpu_if.sv

// ==== Makefile ====
# Verilator build and run of the Q-bus interface testbench

SIM  := obj_dir/Vtb_qbus_cpu_if
SRCS := $(shell grep -v '^+' project.f)

.PHONY: all run clean

all: run

$(SIM): project.f $(SRCS) include/qbus_tb_vectors.svh
	verilator --binary --timing --assert -f project.f --top-module tb_qbus_cpu_if \
		-o Vtb_qbus_cpu_if

run: $(SIM)
	$(SIM) > sim.log 2>&1 || echo "Simulation failed" >> sim.log
	cat sim.log
	! grep -q "Simulation failed" sim.log

clean:
	rm -rf obj_dir sim.log
